// ==== Bender.yml ====
package:
  name: ppu

sources:
  - files:
      - verilog/ppu_pkg.sv
      - verilog/ppu_ifs.sv
      - verilog/ppu_reg_ctrl.sv
      - verilog/ppu_vaddr.sv
      - verilog/ppu_render.sv
      - verilog/ppu_palette.sv
      - verilog/ppu_top.sv
  - target: test
    files:
      - testbench/ppu_vram_model.sv
      - testbench/tb_ppu.sv

// ==== src.f ====
verilog/ppu_pkg.sv
verilog/ppu_ifs.sv
verilog/ppu_reg_ctrl.sv
verilog/ppu_vaddr.sv
verilog/ppu_render.sv
verilog/ppu_palette.sv
verilog/ppu_top.sv
testbench/ppu_vram_model.sv
testbench/tb_ppu.sv

// ==== testbench/ppu_vram_model.sv ====
module ppu_vram_model (
    input  logic        clk,
    input  logic [13:0] addr_i,
    input  logic        wr_i,
    input  logic [7:0]  data_i,
    output logic [7:0]  data_o
);

    logic [7:0] mem [0:16383];

    // tile numbers keep bit 4 clear, so pattern addresses never have bits 9:6 all set
    function automatic logic [7:0] fill_byte(input logic [13:0] a);
        return {a[13:11] ^ a[2:0], 1'b0, a[10:7] ^ a[6:3]};
    endfunction

    initial begin
        for (int i = 0; i < 16384; i++) begin
            mem[i] = fill_byte(14'(i));
        end
    end

    always @(posedge clk) begin
        if (wr_i) begin
            mem[addr_i] <= data_i;
        end
    end

    assign data_o = mem[addr_i];    // answers in the same cycle

endmodule

// ==== testbench/tb_ppu.sv ====
module tb_ppu;

    // longest wait is about one frame, three frames leaves plenty of margin
    localparam int TIMEOUT_CYCLES = 3 * ppu_pkg::DOTS_PER_LINE * ppu_pkg::LINES_PER_FRAME;

    logic        clk = 1'b0;
    logic        rst;
    logic        cs;
    logic        cpu_rw;
    logic [2:0]  cpu_addr;
    logic [7:0]  cpu_wdata;
    logic [7:0]  cpu_rdata;
    logic        nmi;
    logic [13:0] ppu_addr;
    logic [7:0]  ppu_rdata;
    logic [7:0]  ppu_wdata;
    logic        ppu_rd;
    logic        ppu_wr;
    logic [7:0]  px_data;
    logic        px_valid;
    logic        vblank;

    integer      seed = 32'h843e_7e97;
    int          errors = 0;
    int          err_mark = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          cycles = 0;
    int          wr_pulses = 0;
    int          attr_seen = 0;
    logic [13:0] exp_addr = '0;     // address expected on the next vram write
    logic [7:0]  exp_byte = '0;
    logic        pal_window = 1'b0;
    logic        fetch_chk = 1'b0;
    logic [7:0]  byte_log [int];
    logic [7:0]  pal_exp [0:31];
    logic [7:0]  rd;
    logic [7:0]  backdrop;
    int          n;

    always #20 clk = ~clk;

    ppu_top uut (
        .clk        (clk),
        .rst        (rst),
        .cs_i       (cs),
        .cpu_rw_i   (cpu_rw),
        .cpu_addr_i (cpu_addr),
        .cpu_data_i (cpu_wdata),
        .cpu_data_o (cpu_rdata),
        .nmi_o      (nmi),
        .ppu_addr_o (ppu_addr),
        .ppu_data_i (ppu_rdata),
        .ppu_data_o (ppu_wdata),
        .ppu_rd_o   (ppu_rd),
        .ppu_wr_o   (ppu_wr),
        .px_data_o  (px_data),
        .px_valid_o (px_valid),
        .vblank_o   (vblank)
    );

    ppu_vram_model vram (
        .clk    (clk),
        .addr_i (ppu_addr),
        .wr_i   (ppu_wr),
        .data_i (ppu_wdata),
        .data_o (ppu_rdata)
    );

    always @(posedge clk) begin
        cycles++;
        if (ppu_wr) wr_pulses++;
        if (fetch_chk && (&ppu_addr[9:6])) attr_seen++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: no result after %0d clock cycles", TIMEOUT_CYCLES);
            $display("test failed");
            $finish;
        end
    end

    task automatic flag_error(input string msg);
        errors++;
        $display("[FAIL] %0t: %s", $time, msg);
    endtask

    wr_addr_a: assert property (@(posedge clk) disable iff (rst)
        ppu_wr |-> ppu_addr == exp_addr && ppu_wdata == exp_byte)
        else flag_error($sformatf("vram write %04h=%02h, expected %04h=%02h",
                                  ppu_addr, ppu_wdata, exp_addr, exp_byte));
    pal_no_wr_a: assert property (@(posedge clk) disable iff (rst) pal_window |-> !ppu_wr)
        else flag_error($sformatf("vram write at %04h during palette access", ppu_addr));
    nmi_vblank_a: assert property (@(posedge clk) disable iff (rst) nmi |-> vblank)
        else flag_error("nmi high outside vertical blank");
    fetch_range_a: assert property (@(posedge clk) disable iff (rst)
        fetch_chk |-> ppu_addr < 14'h3000)
        else flag_error($sformatf("fetch address %04h above 2fff", ppu_addr));
    attr_page_a: assert property (@(posedge clk) disable iff (rst)
        fetch_chk && (&ppu_addr[9:6]) |-> ppu_addr[13:12] == 2'b10)
        else flag_error($sformatf("attribute address %04h outside the nametables", ppu_addr));

    task automatic cpu_write(input logic [2:0] addr, input logic [7:0] data);
        @(negedge clk);
        cs        = 1'b1;
        cpu_rw    = 1'b0;
        cpu_addr  = addr;
        cpu_wdata = data;
        @(negedge clk);
        cs = 1'b0;
        @(negedge clk);     // let the command strobe land
    endtask

    task automatic cpu_read(input logic [2:0] addr, output logic [7:0] data);
        @(negedge clk);
        cs       = 1'b1;
        cpu_rw   = 1'b1;
        cpu_addr = addr;
        @(negedge clk);
        cs   = 1'b0;
        data = cpu_rdata;   // latched on the edge after detection
        @(negedge clk);
    endtask

    task automatic set_vaddr(input logic [13:0] addr);
        cpu_write(ppu_pkg::PPUADDR, {2'b00, addr[13:8]});
        cpu_write(ppu_pkg::PPUADDR, addr[7:0]);
    endtask

    task automatic vram_burst(input logic [13:0] base, input bit inc32, input int count);
        int          start;
        logic [13:0] a;
        logic [7:0]  d;
        start = wr_pulses;
        cpu_write(ppu_pkg::PPUCTRL, inc32 ? 8'h04 : 8'h00);
        set_vaddr(base);
        a = base;
        for (int i = 0; i < count; i++) begin
            d        = 8'($random(seed));
            exp_addr = a;
            exp_byte = d;
            cpu_write(ppu_pkg::PPUDATA, d);
            byte_log[a] = d;
            a = a + (inc32 ? 14'd32 : 14'd1);
        end
        assert (wr_pulses - start == count)
            else flag_error($sformatf("%0d vram writes, expected %0d", wr_pulses - start, count));
        a = base;
        for (int i = 0; i < count; i++) begin
            assert (vram.mem[a] == byte_log[a])
                else flag_error($sformatf("memory %04h holds %02h", a, vram.mem[a]));
            a = a + (inc32 ? 14'd32 : 14'd1);
        end
    endtask

    // 10/14/18/1c share storage with 00/04/08/0c
    function automatic logic [4:0] backdrop_alias(input logic [4:0] idx);
        return (idx >= 5'h10 && idx[1:0] == 2'b00) ? idx - 5'h10 : idx;
    endfunction

    task automatic end_test(input string name);
        tests_run++;
        if (errors == err_mark) begin
            $display("%0d. %-24s ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("%0d. %-24s %0d error(s)", tests_run, name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    initial begin
        rst       = 1'b1;
        cs        = 1'b0;
        cpu_rw    = 1'b1;
        cpu_addr  = 3'd0;
        cpu_wdata = 8'h00;
        repeat (2) @(negedge clk);
        rst = 1'b0;
        assert (!ppu_wr && ppu_rd && !nmi && !vblank && !px_valid)
            else flag_error("outputs not idle after reset");

        vram_burst(14'h0123, 1'b0, 8);
        vram_burst(14'h0400, 1'b1, 8);
        end_test("address and increment");

        cpu_write(ppu_pkg::PPUCTRL, 8'h00);
        set_vaddr(14'h0126);
        cpu_read(ppu_pkg::PPUDATA, rd);     // primes the buffer
        set_vaddr(14'h0123);
        cpu_read(ppu_pkg::PPUDATA, rd);
        assert (rd == byte_log[14'h0126])
            else flag_error($sformatf("stale read %02h, expected %02h", rd, byte_log[14'h0126]));
        for (int i = 0; i < 4; i++) begin
            cpu_read(ppu_pkg::PPUDATA, rd);
            assert (rd == byte_log[14'h0123 + i])
                else flag_error($sformatf("buffered read %02h, expected %02h",
                                          rd, byte_log[14'h0123 + i]));
        end
        end_test("read buffer");

        pal_window = 1'b1;
        n = wr_pulses;
        set_vaddr({ppu_pkg::PAL_PAGE, 8'h00});
        for (int i = 0; i < 32; i++) begin
            rd = 8'($random(seed));
            cpu_write(ppu_pkg::PPUDATA, rd);
            pal_exp[backdrop_alias(5'(i))] = rd;
        end
        set_vaddr({ppu_pkg::PAL_PAGE, 8'h00});
        for (int i = 0; i < 32; i++) begin
            cpu_read(ppu_pkg::PPUDATA, rd);
            assert (rd == pal_exp[backdrop_alias(5'(i))])
                else flag_error($sformatf("palette %02h read %02h, expected %02h",
                                          i, rd, pal_exp[backdrop_alias(5'(i))]));
        end
        pal_window = 1'b0;
        assert (wr_pulses == n) else flag_error("palette access pulsed the vram write");
        end_test("palette window");

        cpu_write(ppu_pkg::PPUCTRL, 8'h80);
        while (!vblank) @(negedge clk);
        while (!nmi) @(negedge clk);
        assert (vblank) else flag_error("nmi rose without vertical blank");
        cpu_read(ppu_pkg::PPUSTATUS, rd);
        assert (rd[7]) else flag_error($sformatf("first status read %02h, bit 7 clear", rd));
        assert (!nmi) else flag_error("nmi still high after status read");
        cpu_read(ppu_pkg::PPUSTATUS, rd);
        assert (!rd[7]) else flag_error($sformatf("second status read %02h, bit 7 set", rd));
        end_test("vblank and nmi");

        cpu_write(ppu_pkg::PPUCTRL, 8'h00);
        cpu_write(ppu_pkg::PPUMASK, 8'h00);
        backdrop   = 8'($random(seed));
        pal_window = 1'b1;
        set_vaddr({ppu_pkg::PAL_PAGE, 8'h00});
        cpu_write(ppu_pkg::PPUDATA, backdrop);
        pal_window = 1'b0;
        set_vaddr(14'h2000);                // v out of the palette window
        while (vblank) @(negedge clk);
        for (int line = 0; line < 2; line++) begin
            while (!px_valid) @(negedge clk);
            n = 0;
            while (px_valid) begin
                assert (px_data == backdrop)
                    else flag_error($sformatf("pixel %02h, expected %02h", px_data, backdrop));
                n++;
                @(negedge clk);
            end
            assert (n == ppu_pkg::VISIBLE_DOTS)
                else flag_error($sformatf("%0d pixels on a line, expected 256", n));
        end
        end_test("backdrop pixels");

        cpu_write(ppu_pkg::PPUCTRL, 8'h10);     // pattern table at 1000
        cpu_write(ppu_pkg::PPUMASK, 8'h08);
        while (!px_valid) @(negedge clk);
        fetch_chk = 1'b1;
        repeat (2 * ppu_pkg::DOTS_PER_LINE) @(negedge clk);
        fetch_chk = 1'b0;
        assert (attr_seen > 0) else flag_error("no attribute fetch seen on the visible lines");
        end_test("background fetch");

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== verilog/ppu_ifs.sv ====
// register block to scroll/address unit
interface vaddr_cmd_if;
    logic       ctrl_wr;
    logic       scroll_wr;
    logic       addr_wr;
    logic       status_rd;
    logic       inc_v;
    logic       inc32;
    logic [7:0] wdata;
    logic       vpal;   // v inside 3F00-3FFF

    modport ctrl (
        output ctrl_wr, scroll_wr, addr_wr, status_rd, inc_v, inc32, wdata,
        input  vpal
    );

    modport vaddr (
        input  ctrl_wr, scroll_wr, addr_wr, status_rd, inc_v, inc32, wdata,
        output vpal
    );
endinterface

// renderer steps the scroll address
interface scroll_step_if;
    logic        incx;
    logic        incy;
    logic        resetx;
    logic        resety;
    logic [14:0] v;
    logic [2:0]  fine_x;

    modport render (output incx, incy, resetx, resety, input v, fine_x);
    modport vaddr (input incx, incy, resetx, resety, output v, fine_x);
endinterface

// ==== verilog/ppu_palette.sv ====
module ppu_palette (
    input  logic       clk,
    input  logic       rst,
    input  logic       vpal_i,
    input  logic [4:0] v_idx_i,
    input  logic [4:0] render_idx_i,
    input  logic       wr_i,
    input  logic [7:0] data_i,
    output logic [7:0] data_o
);

    logic [7:0] mem [0:31];
    logic [4:0] sel;
    logic [4:0] addr;

    assign sel = vpal_i ? v_idx_i : render_idx_i;

    // sprite backdrops 10/14/18/1C alias the background ones
    assign addr = (sel[1:0] == 2'b00) ? {1'b0, sel[3:0]} : sel;

    always_ff @(posedge clk) begin
        if (wr_i) begin
            mem[addr] <= data_i;
        end
        if (rst) begin
            data_o <= 8'h00;
        end else begin
            data_o <= mem[addr];
        end
    end

endmodule

// ==== verilog/ppu_pkg.sv ====
package ppu_pkg;

    // cpu visible register map, selected by cpu_addr
    typedef enum logic [2:0] {
        PPUCTRL   = 3'd0,
        PPUMASK   = 3'd1,
        PPUSTATUS = 3'd2,
        OAMADDR   = 3'd3,
        OAMDATA   = 3'd4,
        PPUSCROLL = 3'd5,
        PPUADDR   = 3'd6,
        PPUDATA   = 3'd7
    } ppu_reg_e;

    // background fetch phases, two dots each
    typedef enum logic [1:0] {
        FETCH_NT = 2'd0,    // nametable byte
        FETCH_AT = 2'd1,    // attribute byte
        FETCH_LO = 2'd2,    // pattern low plane
        FETCH_HI = 2'd3     // pattern high plane
    } fetch_phase_e;

    // raster geometry
    localparam int DOTS_PER_LINE   = 341;
    localparam int LINES_PER_FRAME = 262;
    localparam int VISIBLE_DOTS    = 256;
    localparam int VISIBLE_LINES   = 240;
    localparam int VBLANK_LINE     = 241;
    localparam int PRERENDER_LINE  = 261;

    // PPUCTRL bits
    localparam int CTRL_INC32    = 2;   // vram step of 32
    localparam int CTRL_BG_TABLE = 4;   // background pattern table
    localparam int CTRL_NMI_EN   = 7;

    // PPUMASK bits
    localparam int MASK_BG_EN = 3;

    // upper six address bits of the palette window
    localparam logic [5:0] PAL_PAGE = 6'h3f;

endpackage

// ==== verilog/ppu_reg_ctrl.sv ====
module ppu_reg_ctrl (
    input  logic              clk,
    input  logic              rst,
    input  logic              cs_i,
    input  logic              cpu_rw_i,
    input  ppu_pkg::ppu_reg_e cpu_addr_i,
    input  logic [7:0]        cpu_data_i,
    output logic [7:0]        cpu_data_o,
    input  logic [7:0]        ppu_data_i,
    input  logic [7:0]        pal_data_i,
    input  logic              vblank_i,
    output logic [7:0]        ppuctrl_o,
    output logic [7:0]        ppumask_o,
    output logic              ppu_wr_o,
    output logic              ppu_rd_o,
    output logic [7:0]        ppu_data_o,
    output logic              pal_wr_o,
    output logic              nmi_o,
    vaddr_cmd_if.ctrl         cmd
);

    logic       cs_r;
    logic       reg_rd;
    logic       reg_wr;
    logic [7:0] io_latch;   // emulates the cpu side bus latch
    logic [7:0] rd_buf;
    logic       buf_load;
    logic       vram_wr;
    logic       vblank_r;
    logic       vblank_rise;
    logic       vblank_fall;
    logic       nmi_occurred;

    // access takes effect on the rising edge of cs
    assign reg_rd = cs_i & ~cs_r & cpu_rw_i;
    assign reg_wr = cs_i & ~cs_r & ~cpu_rw_i;

    assign vblank_rise = vblank_i & ~vblank_r;
    assign vblank_fall = ~vblank_i & vblank_r;

    always_ff @(posedge clk) begin
        if (rst) begin
            cs_r          <= 1'b0;
            vblank_r      <= 1'b0;
            ppuctrl_o     <= 8'h00;
            ppumask_o     <= 8'h00;
            io_latch      <= 8'h00;
            rd_buf        <= 8'h00;
            buf_load      <= 1'b0;
            vram_wr       <= 1'b0;
            pal_wr_o      <= 1'b0;
            nmi_occurred  <= 1'b0;
            cmd.ctrl_wr   <= 1'b0;
            cmd.scroll_wr <= 1'b0;
            cmd.addr_wr   <= 1'b0;
            cmd.status_rd <= 1'b0;
            cmd.inc_v     <= 1'b0;
        end else begin
            cs_r     <= cs_i;
            vblank_r <= vblank_i;

            // strobes default low
            buf_load      <= 1'b0;
            vram_wr       <= 1'b0;
            pal_wr_o      <= 1'b0;
            cmd.ctrl_wr   <= 1'b0;
            cmd.scroll_wr <= 1'b0;
            cmd.addr_wr   <= 1'b0;
            cmd.status_rd <= 1'b0;
            cmd.inc_v     <= 1'b0;

            nmi_occurred <= (nmi_occurred | vblank_rise) & ~vblank_fall;

            // buffer takes the byte at v, before v steps
            if (buf_load) begin
                rd_buf <= ppu_data_i;
            end

            if (reg_rd) begin
                case (cpu_addr_i)
                    ppu_pkg::PPUSTATUS: begin
                        io_latch[7]   <= nmi_occurred; // bits 6:0 stay stale bus data
                        nmi_occurred  <= 1'b0;
                        cmd.status_rd <= 1'b1;
                    end
                    ppu_pkg::PPUDATA: begin
                        // palette bypasses the buffer
                        io_latch  <= cmd.vpal ? pal_data_i : rd_buf;
                        buf_load  <= 1'b1;
                        cmd.inc_v <= 1'b1;
                    end
                    default: begin
                    end
                endcase
            end

            if (reg_wr) begin
                io_latch <= cpu_data_i;
                case (cpu_addr_i)
                    ppu_pkg::PPUCTRL: begin
                        ppuctrl_o   <= cpu_data_i;
                        cmd.ctrl_wr <= 1'b1;    // nametable bits into t
                    end
                    ppu_pkg::PPUMASK:   ppumask_o <= cpu_data_i;
                    ppu_pkg::PPUSCROLL: cmd.scroll_wr <= 1'b1;
                    ppu_pkg::PPUADDR:   cmd.addr_wr <= 1'b1;
                    ppu_pkg::PPUDATA: begin
                        vram_wr   <= ~cmd.vpal;
                        pal_wr_o  <= cmd.vpal;
                        cmd.inc_v <= 1'b1;
                    end
                    default: begin   // oam registers only latch the bus
                    end
                endcase
            end
        end
    end

    assign cmd.wdata = io_latch;
    assign cmd.inc32 = ppuctrl_o[ppu_pkg::CTRL_INC32];

    assign cpu_data_o = io_latch;
    assign ppu_wr_o   = vram_wr;
    assign ppu_rd_o   = ~vram_wr;
    assign ppu_data_o = vram_wr ? io_latch : 8'h00;

    // flag clears one cycle after vblank falls, so gate with the level
    assign nmi_o = nmi_occurred & ppuctrl_o[ppu_pkg::CTRL_NMI_EN] & vblank_i;

    wr_excl_a: assert property (@(posedge clk) disable iff (rst) !(ppu_wr_o && pal_wr_o))
        else $error("vram and palette written together");

    // nmi only after vblank has been up for a cycle
    nmi_vblank_a: assert property (@(posedge clk) disable iff (rst)
        nmi_o |-> vblank_i && $past(vblank_i))
        else $error("nmi outside vertical blank");

endmodule

// ==== verilog/ppu_render.sv ====
module ppu_render (
    input  logic          clk,
    input  logic          rst,
    input  logic [7:0]    ppuctrl_i,
    input  logic [7:0]    ppumask_i,
    input  logic [7:0]    ppu_data_i,
    scroll_step_if.render step,
    output logic [13:0]   ppu_addr_o,
    output logic [4:0]    palette_idx_o,
    output logic          px_en_o,
    output logic          vblank_o
);

    logic [8:0]            dot;
    logic [8:0]            line;
    logic [8:0]            dot_m1;
    ppu_pkg::fetch_phase_e phase;
    logic                  bg_en;
    logic                  active;      // background fetching on this line
    logic                  fetch_dot;
    logic                  tile_end;
    logic                  pix_en;
    logic [7:0]            nt_byte;
    logic [1:0]            at_bits;
    logic [7:0]            pat_lo;
    logic [15:0]           sh_pl, sh_ph, sh_al, sh_ah;   // pattern and attribute shifters
    logic [3:0]            tap;
    logic [3:0]            pix;
    logic [13:0]           pat_base;

    assign dot_m1 = dot - 9'd1;
    assign phase  = ppu_pkg::fetch_phase_e'(dot_m1[2:1]);
    assign bg_en  = ppumask_i[ppu_pkg::MASK_BG_EN];
    assign active = bg_en && (line < ppu_pkg::VISIBLE_LINES || line == ppu_pkg::PRERENDER_LINE);
    assign fetch_dot = (dot >= 1 && dot <= ppu_pkg::VISIBLE_DOTS) || (dot >= 321 && dot <= 336);
    assign tile_end  = active && fetch_dot && dot[2:0] == 3'd0;
    assign pix_en    = line < ppu_pkg::VISIBLE_LINES && dot >= 1 && dot <= ppu_pkg::VISIBLE_DOTS;

    // scroll strobes at fixed dots
    assign step.incx   = tile_end;
    assign step.incy   = active && dot == ppu_pkg::VISIBLE_DOTS;
    assign step.resetx = active && dot == ppu_pkg::VISIBLE_DOTS + 1;
    assign step.resety = bg_en && line == ppu_pkg::PRERENDER_LINE && dot >= 280 && dot <= 304;

    always_ff @(posedge clk) begin
        if (rst) begin
            dot      <= 9'd0;
            line     <= 9'd0;
            vblank_o <= 1'b0;
            px_en_o  <= 1'b0;
        end else begin
            px_en_o <= pix_en;      // lines up with the palette read
            if (dot == ppu_pkg::DOTS_PER_LINE - 1) begin
                dot  <= 9'd0;
                line <= (line == ppu_pkg::LINES_PER_FRAME - 1) ? 9'd0 : line + 9'd1;
            end else begin
                dot <= dot + 9'd1;
            end
            if (dot == 9'd0 && line == ppu_pkg::VBLANK_LINE) vblank_o <= 1'b1;
            if (dot == 9'd0 && line == ppu_pkg::PRERENDER_LINE) vblank_o <= 1'b0;
        end
    end

    // capture at the second dot of each phase
    always_ff @(posedge clk) begin
        if (active && dot_m1[0]) begin
            case (phase)
                ppu_pkg::FETCH_NT: nt_byte <= ppu_data_i;
                ppu_pkg::FETCH_AT: at_bits <= ppu_data_i[{step.v[6], step.v[1], 1'b0} +: 2];
                ppu_pkg::FETCH_LO: pat_lo <= ppu_data_i;
                ppu_pkg::FETCH_HI: begin
                end
            endcase
        end
        if (tile_end) begin
            sh_pl <= {sh_pl[14:7], pat_lo};
            sh_ph <= {sh_ph[14:7], ppu_data_i};     // high plane still on the bus
            sh_al <= {sh_al[14:7], {8{at_bits[0]}}};
            sh_ah <= {sh_ah[14:7], {8{at_bits[1]}}};
        end else if (active && fetch_dot) begin
            sh_pl <= {sh_pl[14:0], 1'b0};
            sh_ph <= {sh_ph[14:0], 1'b0};
            sh_al <= {sh_al[14:0], 1'b0};
            sh_ah <= {sh_ah[14:0], 1'b0};
        end
    end

    assign pat_base = {1'b0, ppuctrl_i[ppu_pkg::CTRL_BG_TABLE], nt_byte, 4'b0000};

    always_comb begin
        ppu_addr_o = step.v[13:0];  // cpu access path
        if (active) begin
            case (phase)
                ppu_pkg::FETCH_NT: ppu_addr_o = {2'b10, step.v[11:0]};
                ppu_pkg::FETCH_AT:
                    ppu_addr_o = {2'b10, step.v[11:10], 4'b1111, step.v[9:7], step.v[4:2]};
                ppu_pkg::FETCH_LO: ppu_addr_o = pat_base | {11'd0, step.v[14:12]};
                ppu_pkg::FETCH_HI: ppu_addr_o = pat_base | {10'd0, 1'b1, step.v[14:12]};
            endcase
        end
    end

    assign tap = 4'd15 - {1'b0, step.fine_x};
    assign pix = {sh_ah[tap], sh_al[tap], sh_ph[tap], sh_pl[tap]};
    assign palette_idx_o = (bg_en && pix[1:0] != 2'b00) ? {1'b0, pix} : 5'd0;

    px_en_a: assert property (@(posedge clk) disable iff (rst)
        px_en_o |-> !vblank_o && $past(dot != 9'd0 && dot <= ppu_pkg::VISIBLE_DOTS))
        else $error("pixel enable outside the visible area");

endmodule

// ==== verilog/ppu_top.sv ====
module ppu_top (
    input  logic        clk,
    input  logic        rst,
    input  logic        cs_i,
    input  logic        cpu_rw_i,
    input  logic [2:0]  cpu_addr_i,
    input  logic [7:0]  cpu_data_i,
    output logic [7:0]  cpu_data_o,
    output logic        nmi_o,
    output logic [13:0] ppu_addr_o,
    input  logic [7:0]  ppu_data_i,
    output logic [7:0]  ppu_data_o,
    output logic        ppu_rd_o,
    output logic        ppu_wr_o,
    output logic [7:0]  px_data_o,
    output logic        px_valid_o,
    output logic        vblank_o
);

    logic [7:0]  ppuctrl;
    logic [7:0]  ppumask;
    logic        pal_wr;
    logic [14:0] v;
    logic [4:0]  palette_idx;

    vaddr_cmd_if   cmd_if ();
    scroll_step_if step_if ();

    ppu_reg_ctrl u_reg_ctrl (
        .clk        (clk),
        .rst        (rst),
        .cs_i       (cs_i),
        .cpu_rw_i   (cpu_rw_i),
        .cpu_addr_i (ppu_pkg::ppu_reg_e'(cpu_addr_i)),
        .cpu_data_i (cpu_data_i),
        .cpu_data_o (cpu_data_o),
        .ppu_data_i (ppu_data_i),
        .pal_data_i (px_data_o),    // palette output doubles as cpu read data
        .vblank_i   (vblank_o),
        .ppuctrl_o  (ppuctrl),
        .ppumask_o  (ppumask),
        .ppu_wr_o   (ppu_wr_o),
        .ppu_rd_o   (ppu_rd_o),
        .ppu_data_o (ppu_data_o),
        .pal_wr_o   (pal_wr),
        .nmi_o      (nmi_o),
        .cmd        (cmd_if)
    );

    ppu_vaddr u_vaddr (
        .clk  (clk),
        .rst  (rst),
        .cmd  (cmd_if),
        .step (step_if),
        .v_o  (v)
    );

    ppu_render u_render (
        .clk           (clk),
        .rst           (rst),
        .ppuctrl_i     (ppuctrl),
        .ppumask_i     (ppumask),
        .ppu_data_i    (ppu_data_i),
        .step          (step_if),
        .ppu_addr_o    (ppu_addr_o),
        .palette_idx_o (palette_idx),
        .px_en_o       (px_valid_o),
        .vblank_o      (vblank_o)
    );

    ppu_palette u_palette (
        .clk          (clk),
        .rst          (rst),
        .vpal_i       (cmd_if.vpal),
        .v_idx_i      (v[4:0]),
        .render_idx_i (palette_idx),
        .wr_i         (pal_wr),
        .data_i       (cpu_data_o),  // latched write byte
        .data_o       (px_data_o)
    );

endmodule

// ==== verilog/ppu_vaddr.sv ====
module ppu_vaddr (
    input  logic         clk,
    input  logic         rst,
    vaddr_cmd_if.vaddr   cmd,
    scroll_step_if.vaddr step,
    output logic [14:0]  v_o
);

    // v and t layout is yyy NN YYYYY XXXXX
    logic [14:0] v;
    logic [14:0] t;
    logic [2:0]  fine_x;
    logic        w;     // first/second write toggle

    always_ff @(posedge clk) begin
        if (rst) begin
            v      <= 15'h0000;
            t      <= 15'h0000;
            fine_x <= 3'd0;
            w      <= 1'b0;
        end else begin
            if (cmd.ctrl_wr) begin
                t[11:10] <= cmd.wdata[1:0];
            end

            if (cmd.scroll_wr) begin
                if (!w) begin
                    t[4:0] <= cmd.wdata[7:3];   // coarse x
                    fine_x <= cmd.wdata[2:0];
                end else begin
                    t[9:5]   <= cmd.wdata[7:3]; // coarse y
                    t[14:12] <= cmd.wdata[2:0];
                end
                w <= ~w;
            end

            if (cmd.addr_wr) begin
                if (!w) begin
                    t[14:8] <= {1'b0, cmd.wdata[5:0]};
                end else begin
                    t[7:0] <= cmd.wdata;
                    v      <= {t[14:8], cmd.wdata};
                end
                w <= ~w;
            end

            if (cmd.status_rd) begin
                w <= 1'b0;
            end

            if (cmd.inc_v) begin
                v <= cmd.inc32 ? v + 15'd32 : v + 15'd1;
            end

            // vertical step at the end of a line
            if (step.incy) begin
                if (&v[14:12]) begin
                    if (v[9:5] == 5'd29) begin
                        v[9:5] <= 5'd0;
                        v[11]  <= ~v[11];       // next vertical nametable
                    end else begin
                        v[9:5] <= v[9:5] + 5'd1; // 30,31 wrap without flip
                    end
                end
                v[14:12] <= v[14:12] + 3'd1;
            end

            if (step.incx) begin
                if (&v[4:0]) begin
                    v[10] <= ~v[10];
                end
                v[4:0] <= v[4:0] + 5'd1;
            end

            if (step.resetx) begin
                v[10]  <= t[10];
                v[4:0] <= t[4:0];
            end

            if (step.resety) begin
                v[14:11] <= t[14:11];
                v[9:5]   <= t[9:5];
            end
        end
    end

    assign cmd.vpal    = (v[13:8] == ppu_pkg::PAL_PAGE);
    assign step.v      = v;
    assign step.fine_x = fine_x;
    assign v_o         = v;

    incx_resetx_a: assert property (@(posedge clk) disable iff (rst)
        !(step.incx && step.resetx))
        else $error("coarse x step and reload in the same dot");

endmodule
